//--- hdl/lcd_pkg.sv
package lcd_pkg;

	// --------------------------------------------------
	// frame format
	// --------------------------------------------------
	localparam logic [8:0] LINE_DOTS     = 9'd456;
	localparam logic [7:0] VISIBLE_LINES = 8'd144;
	localparam logic [7:0] FRAME_LINES   = 8'd154;
	localparam logic [8:0] OAM_DOTS      = 9'd80;
	localparam logic [7:0] PIXEL_END     = 8'd167;  // counts 8..167 reach the lcd
	localparam int         VRAM_AW       = 13;

	// register offsets on the cpu bus
	localparam logic [7:0] ADDR_LCDC = 8'h40;
	localparam logic [7:0] ADDR_STAT = 8'h41;
	localparam logic [7:0] ADDR_SCY  = 8'h42;
	localparam logic [7:0] ADDR_SCX  = 8'h43;
	localparam logic [7:0] ADDR_LY   = 8'h44;
	localparam logic [7:0] ADDR_LYC  = 8'h45;
	localparam logic [7:0] ADDR_BGP  = 8'h47;

	localparam logic [1:0] MODE_HBLANK = 2'd0;
	localparam logic [1:0] MODE_VBLANK = 2'd1;
	localparam logic [1:0] MODE_OAM    = 2'd2;
	localparam logic [1:0] MODE_DRAW   = 2'd3;

	// --------------------------------------------------
	// shared structs
	// --------------------------------------------------
	typedef struct packed {
		logic       sel;
		logic       wr;
		logic [7:0] addr;
		logic [7:0] di;
	} cpu_bus_t;

	typedef struct packed {
		logic lcd_on;
		logic win_map;        // readback only
		logic win_ena;        // readback only
		logic tile_data_sel;  // 1: 0000h unsigned, 0: 1000h signed
		logic bg_map_sel;
		logic spr_size;       // readback only
		logic spr_ena;        // readback only
		logic bg_ena;
	} lcdc_t;

	typedef struct packed {
		lcdc_t      lcdc;
		logic [7:0] scy;
		logic [7:0] scx;
		logic [7:0] bgp;
	} view_regs_t;

	typedef struct packed {
		logic [7:0] ly;
		logic [8:0] h_cnt;
		logic       line_start;  // dot 0 of a visible line
	} line_state_t;

endpackage

//--- hdl/lcd_regs.sv
`timescale 1ns/1ps

module lcd_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  lcd_pkg::cpu_bus_t    cpu,
	input  logic [7:0]           ly,
	input  logic [1:0]           mode,
	input  logic                 lyc_match,
	output logic [7:0]           cpu_do,
	output lcd_pkg::view_regs_t  view,
	output logic [3:0]           stat_ena,
	output logic [7:0]           lyc
);

	lcd_pkg::lcdc_t lcdc;
	logic [7:0]     scy;
	logic [7:0]     scx;
	logic [7:0]     bgp;
	logic           cpu_write;

	assign cpu_write = cpu.sel && cpu.wr;

	// --------------------------------------------------
	// register writes
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			lcdc     <= '0;       // lcd starts switched off
			stat_ena <= 4'd0;
			scy      <= 8'd0;
			scx      <= 8'd0;
			lyc      <= 8'd0;
			bgp      <= 8'hfc;
		end else if (cpu_write) begin
			case (cpu.addr)
				lcd_pkg::ADDR_LCDC: lcdc <= lcd_pkg::lcdc_t'(cpu.di);
				lcd_pkg::ADDR_STAT: stat_ena <= cpu.di[6:3];  // low bits are status
				lcd_pkg::ADDR_SCY:  scy <= cpu.di;
				lcd_pkg::ADDR_SCX:  scx <= cpu.di;
				lcd_pkg::ADDR_LYC:  lyc <= cpu.di;
				lcd_pkg::ADDR_BGP:  bgp <= cpu.di;
				default: ;  // ly is read only
			endcase
		end
	end

	assign view.lcdc = lcdc;
	assign view.scy  = scy;
	assign view.scx  = scx;
	assign view.bgp  = bgp;

	// --------------------------------------------------
	// read mux, no wait state
	// --------------------------------------------------
	always_comb begin
		case (cpu.addr)
			lcd_pkg::ADDR_LCDC: cpu_do = lcdc;
			lcd_pkg::ADDR_STAT: cpu_do = {1'b1, stat_ena, lyc_match, mode};
			lcd_pkg::ADDR_SCY:  cpu_do = scy;
			lcd_pkg::ADDR_SCX:  cpu_do = scx;
			lcd_pkg::ADDR_LY:   cpu_do = ly;
			lcd_pkg::ADDR_LYC:  cpu_do = lyc;
			lcd_pkg::ADDR_BGP:  cpu_do = bgp;
			default:            cpu_do = 8'hff;  // unmapped
		endcase
	end

endmodule

//--- hdl/lcd_timing.sv
`timescale 1ns/1ps

module lcd_timing (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  lcd_on,
	input  logic [3:0]            stat_ena,   // stat bits 6..3
	input  logic [7:0]            lyc,
	input  logic                  line_done,
	output lcd_pkg::line_state_t  line,
	output logic [1:0]            mode,
	output logic                  lyc_match,
	output logic                  irq,
	output logic                  vblank_irq,
	output logic                  lcd_vsync
);

	logic [8:0] h_cnt;
	logic [7:0] ly;
	logic       draw;      // between end of oam scan and line_done
	logic       last_dot;
	logic       visible;
	logic       vblank;

	assign last_dot = (h_cnt == lcd_pkg::LINE_DOTS - 9'd1);
	assign visible  = (ly < lcd_pkg::VISIBLE_LINES);
	assign vblank   = lcd_on && !visible;

	// --------------------------------------------------
	// dot and line counters
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= 9'd0;
			ly    <= 8'd0;
		end else if (!lcd_on) begin
			h_cnt <= 9'd0;  // held until lcdc bit 7 set
			ly    <= 8'd0;
		end else if (last_dot) begin
			h_cnt <= 9'd0;
			if (ly == lcd_pkg::FRAME_LINES - 8'd1)
				ly <= 8'd0;
			else
				ly <= ly + 8'd1;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			draw <= 1'b0;
		end else if (!lcd_on) begin
			draw <= 1'b0;
		end else if (visible && h_cnt == lcd_pkg::OAM_DOTS - 9'd1) begin
			draw <= 1'b1;
		end else if (line_done) begin
			draw <= 1'b0;  // fetcher has sent the last pixel
		end
	end

	// --------------------------------------------------
	// mode and interrupt sources
	// --------------------------------------------------
	always_comb begin
		if (!lcd_on)
			mode = lcd_pkg::MODE_HBLANK;
		else if (!visible)
			mode = lcd_pkg::MODE_VBLANK;
		else if (h_cnt < lcd_pkg::OAM_DOTS)
			mode = lcd_pkg::MODE_OAM;
		else if (draw)
			mode = lcd_pkg::MODE_DRAW;
		else
			mode = lcd_pkg::MODE_HBLANK;
	end

	assign lyc_match = (ly == lyc);

	assign irq = lcd_on && ((stat_ena[3] && lyc_match) ||
		(stat_ena[2] && mode == lcd_pkg::MODE_OAM) ||
		(stat_ena[1] && vblank) ||
		(stat_ena[0] && mode == lcd_pkg::MODE_HBLANK && visible));

	assign vblank_irq = vblank;
	assign lcd_vsync  = lcd_on && (ly == 8'd0);  // whole of line 0

	assign line.ly         = ly;
	assign line.h_cnt      = h_cnt;
	assign line.line_start = lcd_on && visible && (h_cnt == 9'd0);

endmodule

//--- hdl/bg_fetch.sv
`timescale 1ns/1ps

module bg_fetch (
	input  logic                         clk,
	input  logic                         reset,
	input  lcd_pkg::view_regs_t          view,
	input  lcd_pkg::line_state_t         line,
	input  logic [1:0]                   mode,
	output logic                         vram_rd,
	output logic [lcd_pkg::VRAM_AW-1:0]  vram_addr,
	input  logic [7:0]                   vram_data,
	output logic                         line_done,
	output logic                         lcd_clkena,
	output logic [1:0]                   lcd_data
);

	logic       lcd_on;
	logic       mode3;
	logic       preload;
	logic [2:0] fetch_cycle;  // 0-1 map, 2-3 low plane, 4-5 high plane
	logic [3:0] shift_cnt;    // pixels left in the shifter
	logic [2:0] skip_cnt;     // fine scroll pixels still to drop
	logic [7:0] fetch_x;      // screen x of the tile being fetched
	logic [7:0] pcnt;
	logic [7:0] tile_idx;
	logic [7:0] plane_lo;
	logic [7:0] plane_hi;
	logic [7:0] shift_lo;
	logic [7:0] shift_hi;
	logic       fetch_done;
	logic       shift_en;
	logic       reload;
	logic       pix_show;
	logic [7:0] bg_row;
	logic [7:0] bg_col;
	logic       tile_a12;
	logic [1:0] pix;
	logic [1:0] colour;

	assign lcd_on     = view.lcdc.lcd_on;
	assign mode3      = (mode == lcd_pkg::MODE_DRAW);
	assign preload    = (line.h_cnt < lcd_pkg::OAM_DOTS);  // set up during oam scan
	assign fetch_done = (fetch_cycle >= 3'd5);
	assign shift_en   = mode3 && (shift_cnt != 4'd0);
	assign reload     = mode3 && fetch_done && (shift_cnt <= 4'd1);
	assign line_done  = (pcnt == lcd_pkg::PIXEL_END);
	assign pix_show   = shift_en && (skip_cnt == 3'd0) && (pcnt >= 8'd8);

	// --------------------------------------------------
	// fetch sequencer
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_cycle <= 3'd0;
			shift_cnt   <= 4'd0;
			skip_cnt    <= 3'd0;
			fetch_x     <= 8'd0;
		end else if (preload) begin
			fetch_cycle <= 3'd0;
			shift_cnt   <= 4'd0;
			skip_cnt    <= view.scx[2:0];
			fetch_x     <= 8'hf8;  // first tile is hidden behind counts 0..7
		end else if (mode3) begin
			if (fetch_cycle != 3'd7)
				fetch_cycle <= fetch_cycle + 3'd1;
			if (shift_en)
				shift_cnt <= shift_cnt - 4'd1;
			if (shift_en && skip_cnt != 3'd0)
				skip_cnt <= skip_cnt - 3'd1;
			if (reload) begin
				shift_cnt   <= 4'd8;
				fetch_cycle <= 3'd0;  // next tile fetch overlaps the shift out
				fetch_x     <= fetch_x + 8'd8;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			pcnt <= 8'd0;
		else if (!lcd_on || line.line_start)
			pcnt <= 8'd0;
		else if (shift_en && skip_cnt == 3'd0 && !line_done)
			pcnt <= pcnt + 8'd1;
	end

	// vram data is valid on the second dot of each access
	always_ff @(posedge clk) begin
		if (mode3) begin
			if (fetch_cycle == 3'd1)
				tile_idx <= vram_data;
			if (fetch_cycle == 3'd3)
				plane_lo <= vram_data;
			if (fetch_cycle == 3'd5)
				plane_hi <= vram_data;
			if (shift_en) begin
				shift_lo <= shift_lo << 1;
				shift_hi <= shift_hi << 1;
			end
			if (reload) begin
				shift_lo <= plane_lo;
				shift_hi <= (fetch_cycle == 3'd5) ? vram_data : plane_hi;
			end
		end
	end

	// --------------------------------------------------
	// vram addressing
	// --------------------------------------------------
	assign bg_row   = line.ly + view.scy;
	assign bg_col   = fetch_x + view.scx;
	assign tile_a12 = !view.lcdc.tile_data_sel && !tile_idx[7];  // signed 1000h base

	assign vram_rd = mode3 && (fetch_cycle[2:1] != 2'b11);

	always_comb begin
		case (fetch_cycle[2:1])
			2'b00:   vram_addr = {2'b11, view.lcdc.bg_map_sel, bg_row[7:3], bg_col[7:3]};
			2'b01:   vram_addr = {tile_a12, tile_idx, bg_row[2:0], 1'b0};
			default: vram_addr = {tile_a12, tile_idx, bg_row[2:0], 1'b1};
		endcase
	end

	// --------------------------------------------------
	// palette and lcd output
	// --------------------------------------------------
	assign pix = view.lcdc.bg_ena ? {shift_hi[7], shift_lo[7]} : 2'b00;

	always_comb begin
		case (pix)
			2'd0:    colour = view.bgp[1:0];
			2'd1:    colour = view.bgp[3:2];
			2'd2:    colour = view.bgp[5:4];
			default: colour = view.bgp[7:6];
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lcd_clkena <= 1'b0;
			lcd_data   <= 2'd0;
		end else begin
			lcd_clkena <= pix_show;
			if (!lcd_on)
				lcd_data <= 2'd0;  // blank panel
			else if (pix_show)
				lcd_data <= colour;
		end
	end

endmodule

//--- hdl/lcd_video.sv
`timescale 1ns/1ps

module lcd_video (
	input  logic                         clk,
	input  logic                         reset,
	input  lcd_pkg::cpu_bus_t            cpu,
	output logic [7:0]                   cpu_do,
	output logic                         vram_rd,
	output logic [lcd_pkg::VRAM_AW-1:0]  vram_addr,
	input  logic [7:0]                   vram_data,
	output logic                         lcd_on,
	output logic                         lcd_clkena,
	output logic [1:0]                   lcd_data,
	output logic                         lcd_vsync,
	output logic [1:0]                   mode,
	output logic                         irq,
	output logic                         vblank_irq
);

	lcd_pkg::view_regs_t  view;
	lcd_pkg::line_state_t line;
	logic [3:0]           stat_ena;
	logic [7:0]           lyc;
	logic                 lyc_match;
	logic                 line_done;

	assign lcd_on = view.lcdc.lcd_on;

	lcd_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.cpu       (cpu),
		.ly        (line.ly),
		.mode      (mode),
		.lyc_match (lyc_match),
		.cpu_do    (cpu_do),
		.view      (view),
		.stat_ena  (stat_ena),
		.lyc       (lyc)
	);

	lcd_timing u_timing (
		.clk        (clk),
		.reset      (reset),
		.lcd_on     (view.lcdc.lcd_on),
		.stat_ena   (stat_ena),
		.lyc        (lyc),
		.line_done  (line_done),
		.line       (line),
		.mode       (mode),
		.lyc_match  (lyc_match),
		.irq        (irq),
		.vblank_irq (vblank_irq),
		.lcd_vsync  (lcd_vsync)
	);

	bg_fetch u_fetch (
		.clk        (clk),
		.reset      (reset),
		.view       (view),
		.line       (line),
		.mode       (mode),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data),
		.line_done  (line_done),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data)
	);

endmodule

//--- dv/lcd_video_checker.sv
`timescale 1ns/1ps

module lcd_video_checker (
	input logic       clk,
	input logic       reset,
	input logic       lcd_on,
	input logic       lcd_clkena,
	input logic [1:0] mode
);

	logic [8:0] pulse_cnt;  // clkena pulses since the last oam scan

	always_ff @(posedge clk) begin
		if (reset || mode == lcd_pkg::MODE_OAM)
			pulse_cnt <= 9'd0;
		else if (lcd_clkena)
			pulse_cnt <= pulse_cnt + 9'd1;
	end

	// --------------------------------------------------
	// line timing
	// --------------------------------------------------
	oam_length: assert property (@(posedge clk) disable iff (reset || !lcd_on)
		$fell(mode == lcd_pkg::MODE_OAM) |-> (mode == lcd_pkg::MODE_DRAW) &&
		$past(mode == lcd_pkg::MODE_OAM, 80) && !$past(mode == lcd_pkg::MODE_OAM, 81))
		else $error("mode 2 did not last 80 cycles");

	// line 143 runs into vblank instead of another scan
	line_period: assert property (@(posedge clk) disable iff (reset || !lcd_on)
		$rose(mode == lcd_pkg::MODE_OAM) |->
		##456 ($rose(mode == lcd_pkg::MODE_OAM) || mode == lcd_pkg::MODE_VBLANK))
		else $error("line period is not 456 cycles");

	// --------------------------------------------------
	// lcd pixel strobe
	// --------------------------------------------------
	clkena_in_draw: assert property (@(posedge clk) disable iff (reset)
		lcd_clkena |-> $past(mode) == lcd_pkg::MODE_DRAW)
		else $error("lcd_clkena pulse outside mode 3");

	pulses_per_line: assert property (@(posedge clk) disable iff (reset || !lcd_on)
		(mode == lcd_pkg::MODE_HBLANK && $past(mode) == lcd_pkg::MODE_HBLANK &&
		$past(mode, 2) == lcd_pkg::MODE_DRAW) |-> pulse_cnt == 9'd160)
		else $error("line did not carry 160 lcd_clkena pulses");

endmodule

bind lcd_video lcd_video_checker u_checker (
	.clk        (clk),
	.reset      (reset),
	.lcd_on     (lcd_on),
	.lcd_clkena (lcd_clkena),
	.mode       (mode)
);

//--- dv/lcd_video_tb.sv
`timescale 1ns/1ps

module lcd_video_tb;

	localparam int LINE_CYC    = 456;
	localparam int FRAME_CYC   = 456 * 154;
	localparam int WATCHDOG_NS = 7 * FRAME_CYC * 4;  // two frames run, plenty of margin

	logic                 clk = 1'b0;
	logic                 reset;
	lcd_pkg::cpu_bus_t    cpu;
	logic [7:0]           cpu_do;
	logic                 vram_rd;
	logic [12:0]          vram_addr;
	logic [7:0]           vram_q = 8'h00;
	logic                 lcd_on;
	logic                 lcd_clkena;
	logic [1:0]           lcd_data;
	logic                 lcd_vsync;
	logic [1:0]           mode;
	logic                 irq;
	logic                 vblank_irq;
	logic [7:0]           vram [0:8191];
	integer               seed = 32'hae84;
	int                   errors = 0;
	int                   checks = 0;
	logic [7:0]           cur_lcdc, cur_scx, cur_scy, cur_bgp, cur_lyc, rd;

	always #2 clk = ~clk;

	lcd_video DUT (
		.clk(clk), .reset(reset), .cpu(cpu), .cpu_do(cpu_do), .vram_rd(vram_rd),
		.vram_addr(vram_addr), .vram_data(vram_q), .lcd_on(lcd_on),
		.lcd_clkena(lcd_clkena), .lcd_data(lcd_data), .lcd_vsync(lcd_vsync),
		.mode(mode), .irq(irq), .vblank_irq(vblank_irq)
	);

	always @(posedge clk) vram_q <= vram[vram_addr];  // one cycle read latency

	task automatic check_val(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		@(negedge clk);
		cpu = '{sel: 1'b1, wr: 1'b1, addr: addr, di: data};
		@(negedge clk);
		cpu = '{sel: 1'b0, wr: 1'b0, addr: lcd_pkg::ADDR_LY, di: 8'h00};  // park on LY
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
		@(negedge clk);
		cpu = '{sel: 1'b1, wr: 1'b0, addr: addr, di: 8'h00};
		#1 data = cpu_do;
		cpu = '{sel: 1'b0, wr: 1'b0, addr: lcd_pkg::ADDR_LY, di: 8'h00};
	endtask

	// background pixel as the lcd should show it
	function automatic logic [1:0] bg_pixel(input int x, input int y);
		logic [7:0] row, col, idx, lo, hi;
		logic [1:0] pix;
		int         map_a, tile_a;
		row    = 8'(y + int'(cur_scy));
		col    = 8'(x + int'(cur_scx));
		map_a  = 'h1800 + (cur_lcdc[3] ? 'h400 : 0) + int'(row[7:3]) * 32 + int'(col[7:3]);
		idx    = vram[map_a];
		tile_a = cur_lcdc[4] ? int'(idx) * 16 : 'h1000 + int'($signed(idx)) * 16;
		tile_a = tile_a + int'(row[2:0]) * 2;
		lo     = vram[tile_a];
		hi     = vram[tile_a + 1];
		pix    = {hi[3'd7 - col[2:0]], lo[3'd7 - col[2:0]]};
		return cur_bgp[2 * pix +: 2];
	endfunction

	function automatic int legal_step(input logic [1:0] from, input logic [1:0] to);
		case (to)
			lcd_pkg::MODE_DRAW:   return int'(from == lcd_pkg::MODE_OAM);
			lcd_pkg::MODE_HBLANK: return int'(from == lcd_pkg::MODE_DRAW);
			lcd_pkg::MODE_VBLANK: return int'(from == lcd_pkg::MODE_HBLANK);
			default:              return int'(from == lcd_pkg::MODE_HBLANK ||
				from == lcd_pkg::MODE_VBLANK);
		endcase
	endfunction

	// --------------------------------------------------
	// one frame plus one line from lcd switch on
	// --------------------------------------------------
	task automatic watch_frame(input int irq_kind);
		int         ly, prev_ly, xcnt;
		logic [1:0] prev_mode;
		prev_ly   = 0;
		xcnt      = 0;
		prev_mode = lcd_pkg::MODE_HBLANK;
		repeat (FRAME_CYC + LINE_CYC) begin
			@(negedge clk);
			ly = int'(cpu_do);
			check_val("lcd on", 1, int'(lcd_on));
			if (ly != prev_ly)
				check_val("ly step", (prev_ly + 1) % 154, ly);
			check_val("vblank mode", int'(ly >= 144), int'(mode == lcd_pkg::MODE_VBLANK));
			check_val("vblank irq", int'(ly >= 144), int'(vblank_irq));
			check_val("vsync", int'(ly == 0), int'(lcd_vsync));
			if (mode != prev_mode)
				check_val("mode order", 1, legal_step(prev_mode, mode));
			if (mode == lcd_pkg::MODE_OAM)
				xcnt = 0;
			if (lcd_clkena) begin
				check_val("pixel", int'(bg_pixel(xcnt, ly)), int'(lcd_data));
				xcnt++;
			end
			if (irq_kind == 1)
				check_val("irq lyc", int'(ly == int'(cur_lyc)), int'(irq));
			else
				check_val("irq hblank", int'(mode == lcd_pkg::MODE_HBLANK && ly < 144),
					int'(irq));
			prev_ly   = ly;
			prev_mode = mode;
		end
	endtask

	task automatic check_off();
		repeat (3) @(negedge clk);
		repeat (LINE_CYC) begin
			@(negedge clk);
			check_val("off lcd_on", 0, int'(lcd_on));
			check_val("off ly", 0, int'(cpu_do));
			check_val("off mode", 0, int'(mode));
			check_val("off clkena", 0, int'(lcd_clkena));
			check_val("off vram_rd", 0, int'(vram_rd));
			check_val("off lcd_data", 0, int'(lcd_data));
			check_val("off irq", 0, int'(irq | vblank_irq | lcd_vsync));
		end
	endtask

	task automatic set_view(input logic [7:0] lcdc, input logic [7:0] stat);
		cur_scy  = 8'($random(seed));
		cur_bgp  = 8'($random(seed));
		cur_lyc  = 8'(($random(seed) & 32'h7f) + 1);
		cur_lcdc = lcdc;
		write_reg(lcd_pkg::ADDR_SCY, cur_scy);
		write_reg(lcd_pkg::ADDR_SCX, cur_scx);
		write_reg(lcd_pkg::ADDR_BGP, cur_bgp);
		write_reg(lcd_pkg::ADDR_LYC, cur_lyc);
		write_reg(lcd_pkg::ADDR_STAT, stat);
		write_reg(lcd_pkg::ADDR_LCDC, lcdc);  // lcd starts at line 0 here
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		for (int a = 0; a < 8192; a++)
			vram[a] = 8'(a) ^ {3'(a >> 10), 5'(a >> 8)};
		cpu   = '{sel: 1'b0, wr: 1'b0, addr: lcd_pkg::ADDR_LY, di: 8'h00};
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		// register readback, lcd still off
		write_reg(lcd_pkg::ADDR_LCDC, 8'h5b);
		read_reg(lcd_pkg::ADDR_LCDC, rd);
		check_val("read LCDC", 'h5b, int'(rd));
		write_reg(lcd_pkg::ADDR_SCY, 8'h3c);
		read_reg(lcd_pkg::ADDR_SCY, rd);
		check_val("read SCY", 'h3c, int'(rd));
		write_reg(lcd_pkg::ADDR_SCX, 8'ha5);
		read_reg(lcd_pkg::ADDR_SCX, rd);
		check_val("read SCX", 'ha5, int'(rd));
		write_reg(lcd_pkg::ADDR_LYC, 8'h42);
		read_reg(lcd_pkg::ADDR_LYC, rd);
		check_val("read LYC", 'h42, int'(rd));
		write_reg(lcd_pkg::ADDR_BGP, 8'h1e);
		read_reg(lcd_pkg::ADDR_BGP, rd);
		check_val("read BGP", 'h1e, int'(rd));
		write_reg(lcd_pkg::ADDR_STAT, 8'h78);
		read_reg(lcd_pkg::ADDR_STAT, rd);
		check_val("read STAT", 'hf8, int'(rd));  // ly 0, lyc 42h, mode 0
		read_reg(8'h4c, rd);
		check_val("read unmapped", 'hff, int'(rd));

		// coarse scroll only, unsigned tiles, lyc interrupt
		cur_scx = 8'($random(seed)) & 8'hf8;
		set_view(8'h91 | (8'($random(seed)) & 8'h08), 8'h40);
		watch_frame(1);
		write_reg(lcd_pkg::ADDR_LCDC, 8'h11);
		check_off();

		// nonzero fine scroll, signed tiles, hblank interrupt
		cur_scx = 8'($random(seed)) | 8'h05;
		set_view(8'h81 | (8'($random(seed)) & 8'h08), 8'h08);
		watch_frame(2);
		write_reg(lcd_pkg::ADDR_LCDC, 8'h01);
		check_off();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- all.f
hdl/lcd_pkg.sv
hdl/lcd_regs.sv
hdl/lcd_timing.sv
hdl/bg_fetch.sv
hdl/lcd_video.sv
dv/lcd_video_checker.sv
dv/lcd_video_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module lcd_video_tb \
	-f all.f -o lcd_sim > build.log 2>&1 &&
./obj_dir/lcd_sim > sim.log 2>&1 ;
grep -q "^Test OK$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
